// ==== logic/ipv4_fwd_pkg.sv ====
/* shared widths, header offsets and latencies for the ipv4 forwarding slice,
   plus the 16-bit ones'-complement helpers used by both checksum engines */
package ipv4_fwd_pkg;

    //////////////////////////////////////////////////////////////////////
    // stream and header geometry

    localparam int data_bytes = 8;
    localparam int data_width = 8 * data_bytes;
    localparam int hdr_bytes  = 20;
    localparam int hdr_width  = 8 * hdr_bytes;
    localparam int chk_width  = 16;
    // beats needed to cover the whole header
    localparam int hdr_beats  = (hdr_bytes + data_bytes - 1) / data_bytes;

    // byte positions inside the header
    localparam int ttl_offset = 8;
    localparam int chk_offset = 10;

    //////////////////////////////////////////////////////////////////////
    // pipeline timing

    // input beat to output beat, in cycles
    localparam int pipe_depth     = 5;
    localparam int verify_latency = 2;
    localparam int update_latency = 1;

    //////////////////////////////////////////////////////////////////////
    // helpers

    // header word k in network order, byte 2k is the high byte
    function automatic logic [chk_width-1:0] hdr_word(
        input logic [hdr_width-1:0] hdr,
        input int                   k
    );
        return {hdr[8*(2*k) +: 8], hdr[8*(2*k+1) +: 8]};
    endfunction

    // ones'-complement add with end-around carry
    function automatic logic [chk_width-1:0] ones_add(
        input logic [chk_width-1:0] a,
        input logic [chk_width-1:0] b
    );
        logic [chk_width:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[chk_width-1:0] + {{(chk_width-1){1'b0}}, s[chk_width]};
    endfunction

endpackage

// ==== logic/ipv4_header_parser.sv ====
/* finds frame starts on the beat stream, assembles the 20-byte ipv4 header
   and samples the per-frame ingress port and byte length */
`timescale 1ns/1ps

module ipv4_header_parser #(
    parameter int port_width   = 8,
    parameter int length_width = 16
) (
    input  logic                                packet_data_in,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic [ipv4_fwd_pkg::data_width-1:0] in_data,
    input  logic                                in_last,
    input  logic [port_width-1:0]               in_ingress_port,
    input  logic [length_width-1:0]             in_byte_length,
    output logic                                frame_start,
    output logic                                hdr_valid,
    output logic [ipv4_fwd_pkg::hdr_width-1:0]  hdr,
    output logic [port_width-1:0]               meta_port,
    output logic [length_width-1:0]             meta_length
);

    // counter saturates once the header beats are past
    localparam int cnt_width = $clog2(ipv4_fwd_pkg::hdr_beats + 1);

    logic                 sof_pending;
    logic [cnt_width-1:0] beat_cnt;
    logic [cnt_width-1:0] beat_idx;

    // next valid beat after a last beat opens a frame
    assign frame_start = in_valid && sof_pending;
    assign beat_idx    = frame_start ? '0 : beat_cnt;

    always_ff @(posedge packet_data_in) begin
        if (!rst_n) begin
            sof_pending <= 1'b1;
            beat_cnt    <= '0;
            hdr_valid   <= 1'b0;
        end else begin
            // one pulse, the cycle after the final header beat
            hdr_valid <= in_valid &&
                         (beat_idx == cnt_width'(ipv4_fwd_pkg::hdr_beats - 1));
            if (in_valid) begin
                sof_pending <= in_last;
                if (beat_idx != cnt_width'(ipv4_fwd_pkg::hdr_beats)) begin
                    beat_cnt <= beat_idx + 1'b1;
                end else begin
                    beat_cnt <= beat_idx;
                end
            end
        end
    end

    // header bytes land in order, byte i at hdr[8*i +: 8]
    always_ff @(posedge packet_data_in) begin
        if (in_valid) begin
            for (int i = 0; i < ipv4_fwd_pkg::hdr_bytes; i++) begin
                if (beat_idx == cnt_width'(i / ipv4_fwd_pkg::data_bytes)) begin
                    hdr[8*i +: 8] <= in_data[8*(i % ipv4_fwd_pkg::data_bytes) +: 8];
                end
            end
        end
        // metadata held until the next frame start
        if (frame_start) begin
            meta_port   <= in_ingress_port;
            meta_length <= in_byte_length;
        end
    end

endmodule

// ==== logic/ipv4_checksum_verify.sv ====
/* two-stage ipv4 header checksum check, flags pass when the ones'-complement
   sum of all ten header words folds to all ones */
`timescale 1ns/1ps

module ipv4_checksum_verify (
    input  logic                               packet_data_in,
    input  logic                               rst_n,
    input  logic                               hdr_valid,
    input  logic [ipv4_fwd_pkg::hdr_width-1:0] hdr,
    output logic                               chk_ok_valid,
    output logic                               chk_ok
);

    localparam int cw         = ipv4_fwd_pkg::chk_width;
    localparam int half_words = ipv4_fwd_pkg::hdr_width / cw / 2;
    // room for the carries of five words
    localparam int sum_width  = cw + $clog2(half_words);

    logic [sum_width-1:0] part_a;
    logic [sum_width-1:0] part_b;
    logic [sum_width-1:0] sum_a_q;
    logic [sum_width-1:0] sum_b_q;
    logic                 s1_valid;
    logic [sum_width:0]   total;
    logic [cw:0]          fold1;
    logic [cw-1:0]        fold2;

    // stage 1, two partial sums of five words each
    always_comb begin
        part_a = '0;
        part_b = '0;
        for (int k = 0; k < half_words; k++) begin
            part_a = part_a + sum_width'(ipv4_fwd_pkg::hdr_word(hdr, k));
            part_b = part_b + sum_width'(ipv4_fwd_pkg::hdr_word(hdr, k + half_words));
        end
    end

    // stage 2, combine then fold carries twice
    assign total = {1'b0, sum_a_q} + {1'b0, sum_b_q};
    assign fold1 = {1'b0, total[cw-1:0]} + (cw+1)'(total[sum_width:cw]);
    assign fold2 = fold1[cw-1:0] + {{(cw-1){1'b0}}, fold1[cw]};

    always_ff @(posedge packet_data_in) begin
        if (!rst_n) begin
            s1_valid     <= 1'b0;
            chk_ok_valid <= 1'b0;
        end else begin
            s1_valid     <= hdr_valid;
            chk_ok_valid <= s1_valid;
        end
    end

    always_ff @(posedge packet_data_in) begin
        sum_a_q <= part_a;
        sum_b_q <= part_b;
        chk_ok  <= (fold2 == '1);
    end

endmodule

// ==== logic/ipv4_checksum_update.sv ====
/* incremental checksum for a ttl decrement (rfc 1624 eq. 3), one register
   stage after the header strobe */
`timescale 1ns/1ps

module ipv4_checksum_update (
    input  logic                               packet_data_in,
    input  logic                               rst_n,
    input  logic                               hdr_valid,
    input  logic [ipv4_fwd_pkg::hdr_width-1:0] hdr,
    output logic                               new_chk_valid,
    output logic [ipv4_fwd_pkg::chk_width-1:0] new_chk,
    output logic [7:0]                         new_ttl
);

    localparam int cw = ipv4_fwd_pkg::chk_width;

    logic [7:0]    old_ttl;
    logic [7:0]    dec_ttl;
    logic [cw-1:0] old_word;
    logic [cw-1:0] new_word;
    logic [cw-1:0] old_chk;
    logic [cw-1:0] sum;

    // ttl shares its word with protocol
    assign old_ttl  = hdr[8*ipv4_fwd_pkg::ttl_offset +: 8];
    assign dec_ttl  = old_ttl - 8'd1;
    assign old_word = ipv4_fwd_pkg::hdr_word(hdr, ipv4_fwd_pkg::ttl_offset / 2);
    assign new_word = {dec_ttl, old_word[7:0]};
    assign old_chk  = ipv4_fwd_pkg::hdr_word(hdr, ipv4_fwd_pkg::chk_offset / 2);

    // HC' = ~(~HC + ~m + m')
    assign sum = ipv4_fwd_pkg::ones_add(ipv4_fwd_pkg::ones_add(~old_chk, ~old_word),
                                        new_word);

    always_ff @(posedge packet_data_in) begin
        if (!rst_n) begin
            new_chk_valid <= 1'b0;
        end else begin
            new_chk_valid <= hdr_valid;
        end
    end

    always_ff @(posedge packet_data_in) begin
        if (hdr_valid) begin
            new_chk <= ~sum;
            new_ttl <= dec_ttl;
        end
    end

endmodule

// ==== logic/ipv4_frame_rewriter.sv ====
/* delays the beat stream by pipe_depth cycles, patches ttl and checksum on
   beat 1 of good frames, drops zero-keep beats and reports frame status */
`timescale 1ns/1ps

module ipv4_frame_rewriter #(
    parameter int port_width   = 8,
    parameter int length_width = 16
) (
    input  logic                                packet_data_in,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic [ipv4_fwd_pkg::data_width-1:0] in_data,
    input  logic [ipv4_fwd_pkg::data_bytes-1:0] in_keep,
    input  logic                                in_last,
    input  logic                                frame_start,
    input  logic [port_width-1:0]               meta_port,
    input  logic [length_width-1:0]             meta_length,
    input  logic                                chk_ok_valid,
    input  logic                                chk_ok,
    input  logic                                new_chk_valid,
    input  logic [ipv4_fwd_pkg::chk_width-1:0]  new_chk,
    input  logic [7:0]                          new_ttl,
    output logic                                out_valid,
    output logic [ipv4_fwd_pkg::data_width-1:0] out_data,
    output logic [ipv4_fwd_pkg::data_bytes-1:0] out_keep,
    output logic                                out_last,
    output logic                                out_hdr_ok,
    output logic [port_width-1:0]               out_ingress_port,
    output logic [length_width-1:0]             out_byte_length
);

    localparam int depth    = ipv4_fwd_pkg::pipe_depth;
    localparam int dw       = ipv4_fwd_pkg::data_width;
    localparam int db       = ipv4_fwd_pkg::data_bytes;
    // byte lanes of ttl and checksum within beat 1
    localparam int ttl_byte = ipv4_fwd_pkg::ttl_offset - db;
    localparam int chk_byte = ipv4_fwd_pkg::chk_offset - db;

    //////////////////////////////////////////////////////////////////////
    // beat 1 must leave after both engine results are in the slot

    if (depth < ipv4_fwd_pkg::hdr_beats + ipv4_fwd_pkg::verify_latency ||
        depth < ipv4_fwd_pkg::hdr_beats + ipv4_fwd_pkg::update_latency) begin : g_depth_check
        $error("pipe_depth too short for checksum engine latency");
    end

    logic                         fs_d;
    logic [port_width-1:0]        pend_port;
    logic [length_width-1:0]      pend_length;
    logic [port_width-1:0]        slot_port;
    logic [length_width-1:0]      slot_length;
    logic                         slot_ok;
    logic [ipv4_fwd_pkg::chk_width-1:0] slot_chk;
    logic [7:0]                   slot_ttl;
    logic [depth-1:0]             v_line;
    logic [depth-1:0]             last_line;
    logic [depth-1:0]             tag_line;
    logic [depth-1:0][dw-1:0]     data_line;
    logic [depth-1:0][db-1:0]     keep_line;
    logic [7:0]                   old_ttl;
    logic                         rewrite;
    logic                         keep_nz;

    //////////////////////////////////////////////////////////////////////
    // delay line, tag marks the second beat of each frame

    always_ff @(posedge packet_data_in) begin
        if (!rst_n) begin
            fs_d      <= 1'b0;
            v_line    <= '0;
            last_line <= '0;
        end else begin
            fs_d      <= frame_start;
            v_line    <= {v_line[depth-2:0], in_valid};
            last_line <= {last_line[depth-2:0], in_valid && in_last};
        end
    end

    always_ff @(posedge packet_data_in) begin
        tag_line  <= {tag_line[depth-2:0], fs_d && in_valid};
        data_line <= {data_line[depth-2:0], in_data};
        keep_line <= {keep_line[depth-2:0], in_keep};
    end

    //////////////////////////////////////////////////////////////////////
    // per-frame slot

    always_ff @(posedge packet_data_in) begin
        // parser metadata is valid the cycle after frame start
        if (fs_d) begin
            pend_port   <= meta_port;
            pend_length <= meta_length;
        end
        // moved on with the update result, survives until next frame's result
        if (new_chk_valid) begin
            slot_chk    <= new_chk;
            slot_ttl    <= new_ttl;
            slot_port   <= pend_port;
            slot_length <= pend_length;
        end
        if (chk_ok_valid) begin
            slot_ok <= chk_ok;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output side

    assign old_ttl = data_line[depth-1][8*ttl_byte +: 8];
    // ttl of 0 or 1 is left for the slow path
    assign rewrite = tag_line[depth-1] && slot_ok && (old_ttl > 8'd1);
    assign keep_nz = |keep_line[depth-1];

    always_comb begin
        out_data = data_line[depth-1];
        if (rewrite) begin
            out_data[8*ttl_byte +: 8]       = slot_ttl;
            out_data[8*chk_byte +: 8]       = slot_chk[15:8];
            out_data[8*(chk_byte + 1) +: 8] = slot_chk[7:0];
        end
    end

    assign out_keep         = keep_line[depth-1];
    assign out_valid        = v_line[depth-1] && keep_nz;
    assign out_last         = last_line[depth-1] && keep_nz;
    assign out_hdr_ok       = slot_ok;
    assign out_ingress_port = slot_port;
    assign out_byte_length  = slot_length;

endmodule

// ==== logic/ipv4_fwd_top.sv ====
/* ipv4 forwarding slice: parser feeds the checksum verifier and updater,
   the rewriter merges their results back into the delayed stream */
`timescale 1ns/1ps

module ipv4_fwd_top #(
    parameter int port_width   = 8,
    parameter int length_width = 16
) (
    input  logic                                packet_data_in,
    input  logic                                rst_n,
    input  logic                                in_valid,
    input  logic [ipv4_fwd_pkg::data_width-1:0] in_data,
    input  logic [ipv4_fwd_pkg::data_bytes-1:0] in_keep,
    input  logic                                in_last,
    input  logic [port_width-1:0]               in_ingress_port,
    input  logic [length_width-1:0]             in_byte_length,
    output logic                                out_valid,
    output logic [ipv4_fwd_pkg::data_width-1:0] out_data,
    output logic [ipv4_fwd_pkg::data_bytes-1:0] out_keep,
    output logic                                out_last,
    output logic                                out_hdr_ok,
    output logic [port_width-1:0]               out_ingress_port,
    output logic [length_width-1:0]             out_byte_length
);

    //////////////////////////////////////////////////////////////////////
    // internal links

    logic                               frame_start;
    logic                               hdr_valid;
    logic [ipv4_fwd_pkg::hdr_width-1:0] hdr;
    logic [port_width-1:0]              meta_port;
    logic [length_width-1:0]            meta_length;
    logic                               chk_ok_valid;
    logic                               chk_ok;
    logic                               new_chk_valid;
    logic [ipv4_fwd_pkg::chk_width-1:0] new_chk;
    logic [7:0]                         new_ttl;

    // decode
    ipv4_header_parser #(
        .port_width   (port_width),
        .length_width (length_width)
    ) u_parser (
        .packet_data_in  (packet_data_in),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_data         (in_data),
        .in_last         (in_last),
        .in_ingress_port (in_ingress_port),
        .in_byte_length  (in_byte_length),
        .frame_start     (frame_start),
        .hdr_valid       (hdr_valid),
        .hdr             (hdr),
        .meta_port       (meta_port),
        .meta_length     (meta_length)
    );

    // execute, both engines see the same header strobe
    ipv4_checksum_verify u_verify (
        .packet_data_in (packet_data_in),
        .rst_n          (rst_n),
        .hdr_valid      (hdr_valid),
        .hdr            (hdr),
        .chk_ok_valid   (chk_ok_valid),
        .chk_ok         (chk_ok)
    );

    ipv4_checksum_update u_update (
        .packet_data_in (packet_data_in),
        .rst_n          (rst_n),
        .hdr_valid      (hdr_valid),
        .hdr            (hdr),
        .new_chk_valid  (new_chk_valid),
        .new_chk        (new_chk),
        .new_ttl        (new_ttl)
    );

    // result
    ipv4_frame_rewriter #(
        .port_width   (port_width),
        .length_width (length_width)
    ) u_rewriter (
        .packet_data_in   (packet_data_in),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .in_data          (in_data),
        .in_keep          (in_keep),
        .in_last          (in_last),
        .frame_start      (frame_start),
        .meta_port        (meta_port),
        .meta_length      (meta_length),
        .chk_ok_valid     (chk_ok_valid),
        .chk_ok           (chk_ok),
        .new_chk_valid    (new_chk_valid),
        .new_chk          (new_chk),
        .new_ttl          (new_ttl),
        .out_valid        (out_valid),
        .out_data         (out_data),
        .out_keep         (out_keep),
        .out_last         (out_last),
        .out_hdr_ok       (out_hdr_ok),
        .out_ingress_port (out_ingress_port),
        .out_byte_length  (out_byte_length)
    );

endmodule

// ==== verification/ipv4_fwd_properties.sv ====
/* concurrent checks on the slice strobes, bound into the top level */
`timescale 1ns/1ps

module ipv4_fwd_properties (
    input logic packet_data_in,
    input logic rst_n,
    input logic out_valid,
    input logic out_last,
    input logic hdr_valid,
    input logic chk_ok_valid
);

    // failed assertions seen so far
    int fail_count = 0;

    // last only ever rides on a valid beat
    last_needs_valid: assert property (@(posedge packet_data_in) disable iff (!rst_n)
        !(out_last && !out_valid))
        else begin
            fail_count++;
            $error("out_last high without out_valid");
        end

    // delay line is empty right after reset
    quiet_after_reset: assert property (@(posedge packet_data_in)
        $rose(rst_n) |-> !out_valid ##1 !out_valid ##1 !out_valid ##1 !out_valid ##1 !out_valid)
        else begin
            fail_count++;
            $error("out_valid high within 5 cycles of reset release");
        end

    // verifier latency checked in both directions
    verify_follows_hdr: assert property (@(posedge packet_data_in) disable iff (!rst_n)
        hdr_valid |-> ##2 chk_ok_valid)
        else begin
            fail_count++;
            $error("chk_ok_valid missing 2 cycles after hdr_valid");
        end

    verify_has_cause: assert property (@(posedge packet_data_in) disable iff (!rst_n)
        chk_ok_valid |-> $past(hdr_valid, 2))
        else begin
            fail_count++;
            $error("chk_ok_valid without hdr_valid 2 cycles before");
        end

endmodule

// ==== verification/ipv4_fwd_checker.sv ====
/* watches the slice outputs on the falling edge and compares each beat with
   the expectations queued by the testbench, one line per frame */
`timescale 1ns/1ps

module ipv4_fwd_checker (
    input logic                                packet_data_in,
    input logic                                rst_n,
    input logic                                out_valid,
    input logic [ipv4_fwd_pkg::data_width-1:0] out_data,
    input logic [ipv4_fwd_pkg::data_bytes-1:0] out_keep,
    input logic                                out_last,
    input logic                                out_hdr_ok,
    input logic [7:0]                          out_ingress_port,
    input logic [15:0]                         out_byte_length
);

    // beat expectations
    logic [63:0] exp_data_q [$];
    logic [7:0]  exp_keep_q [$];
    logic        exp_last_q [$];
    logic [63:0] exp_time_q [$];

    // frame expectations
    int          frame_id_q [$];
    logic        exp_ok_q   [$];
    logic [63:0] exp_port_q [$];
    logic [63:0] exp_len_q  [$];

    int frames_done  = 0;
    int error_count  = 0;
    int check_count  = 0;
    int frame_errors = 0;

    task automatic add_frame(input int id, input logic ok, input logic [63:0] port,
                             input logic [63:0] len);
        frame_id_q.push_back(id);
        exp_ok_q.push_back(ok);
        exp_port_q.push_back(port);
        exp_len_q.push_back(len);
    endtask

    task automatic add_beat(input logic [63:0] data, input logic [7:0] keep,
                            input logic last, input logic [63:0] t);
        exp_data_q.push_back(data);
        exp_keep_q.push_back(keep);
        exp_last_q.push_back(last);
        exp_time_q.push_back(t);
    endtask

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            frame_errors++;
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // outputs are register driven, stable at the falling edge

    always @(negedge packet_data_in) begin
        if (rst_n && out_valid) begin
            if (exp_data_q.size() == 0) begin
                error_count++;
                $display("output beat at %0t ns with no beat expected", $time);
            end else begin
                // arrival time covers the fixed latency
                compare("out_valid time", exp_time_q.pop_front(), 64'($time));
                compare("out_data", exp_data_q.pop_front(), out_data);
                compare("out_keep", 64'(exp_keep_q.pop_front()), 64'(out_keep));
                if (exp_last_q.pop_front()) begin
                    compare("out_last", 64'd1, 64'(out_last));
                    compare("out_hdr_ok", 64'(exp_ok_q.pop_front()), 64'(out_hdr_ok));
                    compare("out_ingress_port", exp_port_q.pop_front(), 64'(out_ingress_port));
                    compare("out_byte_length", exp_len_q.pop_front(), 64'(out_byte_length));
                    $display("frame %0d: %s", frame_id_q.pop_front(),
                             (frame_errors == 0) ? "ok" : "mismatch");
                    frames_done++;
                    frame_errors = 0;
                end else begin
                    compare("out_last", 64'd0, 64'(out_last));
                end
            end
        end
    end

endmodule

// ==== verification/ipv4_fwd_tb.sv ====
/* testbench top that drives a table of ipv4 frames into the forwarding slice
   and hands each expected output beat to the checker */
`timescale 1ns/1ps

module ipv4_fwd_tb;

    localparam int n_frames    = 8;
    localparam int max_bytes   = 48;
    localparam int period      = 100;
    localparam int drain_limit = 200;

    typedef struct {
        logic [7:0]  ttl;
        logic        corrupt;
        int          beats;
        int          zero_beat;
        logic        no_gap;
        logic [7:0]  port;
        logic [15:0] length;
        logic [7:0]  exp_ttl;
        logic        exp_ok;
    } frame_t;

    logic                                packet_data_in;
    logic                                rst_n;
    logic                                in_valid;
    logic [ipv4_fwd_pkg::data_width-1:0] in_data;
    logic [ipv4_fwd_pkg::data_bytes-1:0] in_keep;
    logic                                in_last;
    logic [7:0]                          in_ingress_port;
    logic [15:0]                         in_byte_length;
    logic                                out_valid;
    logic [ipv4_fwd_pkg::data_width-1:0] out_data;
    logic [ipv4_fwd_pkg::data_bytes-1:0] out_keep;
    logic                                out_last;
    logic                                out_hdr_ok;
    logic [7:0]                          out_ingress_port;
    logic [15:0]                         out_byte_length;

    frame_t      tbl [n_frames];
    logic [7:0]  frame_bytes [max_bytes];
    logic [31:0] lcg_state;
    int          waited;

    ipv4_fwd_top uut (.*);

    ipv4_fwd_checker chk (
        .packet_data_in   (packet_data_in),
        .rst_n            (rst_n),
        .out_valid        (out_valid),
        .out_data         (out_data),
        .out_keep         (out_keep),
        .out_last         (out_last),
        .out_hdr_ok       (out_hdr_ok),
        .out_ingress_port (out_ingress_port),
        .out_byte_length  (out_byte_length)
    );

    initial packet_data_in = 1'b0;
    always #50 packet_data_in = ~packet_data_in;

    //////////////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [7:0] next_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // ones'-complement add with end-around carry
    function automatic logic [15:0] csum_add(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[15:0] + {15'd0, s[16]};
    endfunction

    // ttl, corrupt, beats, zero beat, no gap, port, length, expected ttl, expected ok
    task automatic load_table();
        tbl[0] = '{8'd64,  1'b0, 3, 0, 1'b0, 8'd1,  16'd24, 8'd63,  1'b1};
        tbl[1] = '{8'd64,  1'b1, 4, 0, 1'b0, 8'd2,  16'd32, 8'd64,  1'b0};
        tbl[2] = '{8'd1,   1'b0, 3, 0, 1'b0, 8'd3,  16'd21, 8'd1,   1'b1};
        tbl[3] = '{8'd0,   1'b0, 4, 0, 1'b0, 8'd4,  16'd30, 8'd0,   1'b1};
        tbl[4] = '{8'd128, 1'b0, 5, 3, 1'b1, 8'd5,  16'd40, 8'd127, 1'b1};
        tbl[5] = '{8'd2,   1'b0, 3, 0, 1'b1, 8'd6,  16'd22, 8'd1,   1'b1};
        tbl[6] = '{8'd255, 1'b1, 6, 2, 1'b1, 8'd7,  16'd48, 8'd255, 1'b0};
        tbl[7] = '{8'd33,  1'b0, 3, 0, 1'b0, 8'd8,  16'd23, 8'd32,  1'b1};
    endtask

    //////////////////////////////////////////////////////////////////////
    // builds one frame and its expectations, then drives its beats

    task automatic drive_frame(input int idx);
        frame_t      f;
        logic [15:0] sum;
        logic [15:0] chk_word;
        logic [15:0] old_word;
        logic [15:0] new_word;
        logic [15:0] new_chk;
        logic [63:0] beat;
        logic [63:0] exp_beat;
        int          gap;
        f = tbl[idx];
        for (int i = 0; i < max_bytes; i++) begin
            frame_bytes[i] = next_byte();
        end
        frame_bytes[0]  = 8'h45;
        frame_bytes[2]  = f.length[15:8];
        frame_bytes[3]  = f.length[7:0];
        frame_bytes[8]  = f.ttl;
        frame_bytes[10] = 8'h00;
        frame_bytes[11] = 8'h00;
        // full header sum with the checksum field zeroed
        sum = 16'h0000;
        for (int k = 0; k < 10; k++) begin
            sum = csum_add(sum, {frame_bytes[2*k], frame_bytes[2*k+1]});
        end
        chk_word = ~sum;
        if (f.corrupt) begin
            chk_word = chk_word ^ 16'h0101;
        end
        frame_bytes[10] = chk_word[15:8];
        frame_bytes[11] = chk_word[7:0];
        // rfc 1624 eq. 3 on the ttl/protocol word
        old_word = {f.ttl, frame_bytes[9]};
        new_word = {f.exp_ttl, frame_bytes[9]};
        new_chk  = ~csum_add(csum_add(~chk_word, ~old_word), new_word);

        if (!f.no_gap) begin
            gap = 1 + int'(next_byte()) % 3;
            repeat (gap) begin
                @(negedge packet_data_in);
                in_valid = 1'b0;
                in_last  = 1'b0;
            end
        end
        chk.add_frame(idx, f.exp_ok, 64'(f.port), 64'(f.length));

        for (int b = 0; b < f.beats; b++) begin
            for (int j = 0; j < 8; j++) begin
                beat[8*j +: 8] = frame_bytes[8*b + j];
            end
            exp_beat = beat;
            // beat 1 carries ttl at lane 0 and checksum at lanes 2 and 3
            if (b == 1 && f.exp_ttl != f.ttl) begin
                exp_beat[7:0]   = f.exp_ttl;
                exp_beat[23:16] = new_chk[15:8];
                exp_beat[31:24] = new_chk[7:0];
            end
            @(negedge packet_data_in);
            in_valid = 1'b1;
            in_data  = beat;
            in_keep  = (f.zero_beat != 0 && b == f.zero_beat) ? 8'h00 : 8'hff;
            in_last  = (b == f.beats - 1);
            // later beats carry noise metadata
            if (b == 0) begin
                in_ingress_port = f.port;
                in_byte_length  = f.length;
            end else begin
                in_ingress_port = next_byte();
                in_byte_length  = {next_byte(), next_byte()};
            end
            if (in_keep != 8'h00) begin
                chk.add_beat(exp_beat, 8'hff, in_last,
                             $time + 64'(ipv4_fwd_pkg::pipe_depth * period));
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        lcg_state       = 32'd92467;
        rst_n           = 1'b0;
        in_valid        = 1'b0;
        in_data         = '0;
        in_keep         = '0;
        in_last         = 1'b0;
        in_ingress_port = '0;
        in_byte_length  = '0;
        load_table();
        repeat (5) @(negedge packet_data_in);
        rst_n = 1'b1;

        for (int idx = 0; idx < n_frames; idx++) begin
            drive_frame(idx);
        end
        @(negedge packet_data_in);
        in_valid = 1'b0;
        in_last  = 1'b0;
        in_keep  = '0;

        // drain the delay line
        waited = 0;
        while (chk.frames_done < n_frames && waited < drain_limit) begin
            @(negedge packet_data_in);
            waited++;
        end

        $display("frames %0d of %0d, checks %0d, errors %0d, assertion failures %0d",
                 chk.frames_done, n_frames, chk.check_count, chk.error_count,
                 uut.props.fail_count);
        if (chk.frames_done < n_frames) begin
            $display("timeout: not every frame reached the output");
            $display("Finished with errors");
        end else if (chk.error_count != 0 || uut.props.fail_count != 0) begin
            $display("Finished with errors");
        end else begin
            $display("Finished with no errors");
        end
        $finish;
    end

endmodule

bind ipv4_fwd_top ipv4_fwd_properties props (
    .packet_data_in (packet_data_in),
    .rst_n          (rst_n),
    .out_valid      (out_valid),
    .out_last       (out_last),
    .hdr_valid      (hdr_valid),
    .chk_ok_valid   (chk_ok_valid)
);

// ==== ipv4_fwd_top.f ====
logic/ipv4_fwd_pkg.sv
logic/ipv4_header_parser.sv
logic/ipv4_checksum_verify.sv
logic/ipv4_checksum_update.sv
logic/ipv4_frame_rewriter.sv
logic/ipv4_fwd_top.sv
verification/ipv4_fwd_properties.sv
verification/ipv4_fwd_checker.sv
verification/ipv4_fwd_tb.sv

// ==== Makefile ====
# Verilator build and run for the ipv4 forwarding slice

VERILATOR ?= verilator
TOP       ?= ipv4_fwd_tb
FILELIST  ?= ipv4_fwd_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
